/* usb_xact_pkg.sv */
package usb_xact_pkg;

  // Field widths seen at the decoder/encoder boundary
  localparam int ADDR_W = 7;
  localparam int ENDP_W = 4;
  localparam int TUSER_W = 4;

  // One DATA0/DATA1 toggle per possible endpoint number
  localparam int NUM_TOGGLE = 16;

  // Token PID class, as carried in tuser[3:2] by the decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_t;

  // Handshake PID class
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_type_t;

  // Data PID class, low tuser bits 2'b11 mark a data packet
  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } data_pid_t;

  // Transaction dispatcher states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BULK,
    ST_DUMP
  } xact_state_t;

  // Bulk engine states
  typedef enum logic [2:0] {
    BLK_IDLE,
    BLK_DATI_TX,
    BLK_DATI_ZDP,
    BLK_DATI_ACK,
    BLK_DATO_RX,
    BLK_DATO_NAK_RX,
    BLK_DATO_HSK,
    BLK_DONE
  } bulk_state_t;

  // Error codes reported to the user side
  typedef enum logic [2:0] {
    ER_NONE = 3'h0,
    ER_TOKN = 3'h3,
    ER_ENDP = 3'h5
  } err_code_t;

endpackage

/* xact_if.sv */
`timescale 1ns/1ps
interface xact_if
  import usb_xact_pkg::*;
();

  // One-cycle pulse when the dispatcher opens a bulk transaction
  logic start;

  // Token details, held for the whole transaction
  tok_type_t tok_type;
  logic [ENDP_W-1:0] endp;

  // Level from the engine once the transaction is complete
  logic done;

  modport dispatch(
    output start,
    output tok_type,
    output endp,
    input done
  );

  modport engine(
    input start,
    input tok_type,
    input endp,
    output done
  );

endinterface

/* token_dispatch.sv */
`timescale 1ns/1ps
module token_dispatch
  import usb_xact_pkg::*;
#(
  parameter int BULK_EP_A = 1,
  parameter int BULK_EP_B = 2
) (
  input  logic              clock,
  input  logic              reset,
  input  logic [ADDR_W-1:0] usb_addr_i,
  input  logic              tok_recv_i,
  input  logic [ADDR_W-1:0] tok_addr_i,
  input  logic [ENDP_W-1:0] tok_endp_i,
  input  tok_type_t         tok_type_i,
  xact_if.dispatch          xact,
  output err_code_t         err_code_o,
  output logic              blk_cycle_o
);

  localparam logic [ENDP_W-1:0] EP_A = ENDP_W'(BULK_EP_A);
  localparam logic [ENDP_W-1:0] EP_B = ENDP_W'(BULK_EP_B);

  xact_state_t state_q;
  err_code_t err_q;
  logic start_q;
  tok_type_t tok_type_q;
  logic [ENDP_W-1:0] endp_q;

  // Token for this device, whatever its type
  logic tok_hit_w;
  logic tok_bulk_w;
  logic endp_ok_w;

  assign tok_hit_w = tok_recv_i && (tok_addr_i == usb_addr_i);
  assign tok_bulk_w = (tok_type_i == TOK_IN) || (tok_type_i == TOK_OUT);
  assign endp_ok_w = (tok_endp_i == EP_A) || (tok_endp_i == EP_B);

  // Token details ride alongside the transaction
  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE && tok_hit_w) begin
      tok_type_q <= tok_type_i;
      endp_q <= tok_endp_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
      err_q <= ER_NONE;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          err_q <= ER_NONE;
          if (tok_hit_w && tok_bulk_w) begin
            // Bad endpoint still runs the bulk engine, but is flagged
            state_q <= ST_BULK;
            start_q <= 1'b1;
            err_q <= endp_ok_w ? ER_NONE : ER_ENDP;
          end else if (tok_hit_w) begin
            // SOF, SETUP and anything else are not handled here
            state_q <= ST_DUMP;
            err_q <= ER_TOKN;
          end
        end
        ST_BULK: begin
          // Engine finished, hand control back
          if (xact.done) begin
            state_q <= ST_IDLE;
          end
        end
        ST_DUMP: begin
          // Stuck here until reset
          state_q <= ST_DUMP;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign xact.start = start_q;
  assign xact.tok_type = tok_type_q;
  assign xact.endp = endp_q;

  assign err_code_o = err_q;
  assign blk_cycle_o = (state_q == ST_BULK);

endmodule

/* handshake_issuer.sv */
`timescale 1ns/1ps
module handshake_issuer
  import usb_xact_pkg::*;
#(
  parameter int EOP_DELAY = 5
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      usb_recv_i,
  input  logic      hsk_req_i,
  input  hsk_type_t hsk_type_i,
  input  logic      hsk_sent_i,
  output logic      eop_rx_o,
  output logic      hsk_send_o,
  output hsk_type_t hsk_type_o
);

  localparam int CNT_W = $clog2(EOP_DELAY + 1);

  logic [CNT_W-1:0] cnt_q;
  logic eop_rx_q;
  logic send_q;
  hsk_type_t type_q;

  // Counts down from packet receive to the end of its EOP
  always_ff @(posedge clock) begin
    if (reset) begin
      cnt_q <= '0;
      eop_rx_q <= 1'b0;
    end else begin
      if (usb_recv_i) begin
        cnt_q <= CNT_W'(EOP_DELAY);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // A fresh packet restarts the wait
      eop_rx_q <= (cnt_q == CNT_W'(1)) && !usb_recv_i;
    end
  end

  // Handshake goes out once the bus has turned around
  always_ff @(posedge clock) begin
    if (reset) begin
      send_q <= 1'b0;
    end else if (!send_q && eop_rx_q && hsk_req_i) begin
      send_q <= 1'b1;
    end else if (hsk_sent_i) begin
      send_q <= 1'b0;
    end
  end

  // Type captured with the request, held while sending
  always_ff @(posedge clock) begin
    if (!send_q && eop_rx_q && hsk_req_i) begin
      type_q <= hsk_type_i;
    end
  end

  assign eop_rx_o = eop_rx_q;
  assign hsk_send_o = send_q;
  assign hsk_type_o = type_q;

endmodule

/* bulk_engine.sv */
`timescale 1ns/1ps
module bulk_engine
  import usb_xact_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  xact_if.engine             xact,
  input  logic               blk_in_ready_i,
  input  logic               blk_out_ready_i,
  input  logic               usb_sent_i,
  input  logic               eop_rx_i,
  input  logic               hsk_recv_i,
  input  logic               hsk_sent_i,
  input  logic [TUSER_W-1:0] usb_tuser_i,
  // Bulk IN source
  input  logic               blk_tvalid_i,
  output logic               blk_tready_o,
  input  logic               blk_tlast_i,
  input  logic               blk_tkeep_i,
  input  logic [7:0]         blk_tdata_i,
  // Host OUT data, forwarded to the bulk OUT sink
  input  logic               usb_tvalid_i,
  output logic               usb_tready_o,
  input  logic               usb_tlast_i,
  input  logic               usb_tkeep_i,
  input  logic [7:0]         usb_tdata_i,
  output logic               blk_tvalid_o,
  input  logic               blk_tready_i,
  output logic               blk_tlast_o,
  output logic               blk_tkeep_o,
  output logic [7:0]         blk_tdata_o,
  // To the packet encoder and handshake issuer
  output logic               usb_tvalid_o,
  input  logic               usb_tready_i,
  output logic               usb_tlast_o,
  output logic               usb_tkeep_o,
  output logic [7:0]         usb_tdata_o,
  output logic [TUSER_W-1:0] usb_tuser_o,
  output logic               hsk_req_o,
  output hsk_type_t          hsk_type_o
);

  bulk_state_t state_q;
  logic zdp_q;
  logic nak_q;
  logic [NUM_TOGGLE-1:0] toggle_q;

  logic sel_tx_w;
  logic rx_last_w;
  logic hsk_ack_rx_w;
  logic odd_w;

  assign sel_tx_w = (state_q == BLK_DATI_TX);
  assign rx_last_w = usb_tvalid_i && usb_tready_o && usb_tlast_i;
  assign hsk_ack_rx_w = hsk_recv_i && (usb_tuser_i[3:2] == HSK_ACK);
  assign odd_w = toggle_q[xact.endp];

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= BLK_IDLE;
      zdp_q <= 1'b0;
      nak_q <= 1'b0;
    end else begin
      case (state_q)
        BLK_IDLE: begin
          // Direction from the token, path from the user readiness
          if (xact.start && xact.tok_type == TOK_IN) begin
            state_q <= blk_in_ready_i ? BLK_DATI_TX : BLK_DATI_ZDP;
            zdp_q <= !blk_in_ready_i;
          end else if (xact.start) begin
            state_q <= blk_out_ready_i ? BLK_DATO_RX : BLK_DATO_NAK_RX;
            nak_q <= !blk_out_ready_i;
          end
        end
        BLK_DATI_TX: begin
          if (usb_sent_i) begin
            state_q <= BLK_DATI_ACK;
          end
        end
        BLK_DATI_ZDP: begin
          // Single empty beat, gone once the encoder takes it
          if (usb_tvalid_o && usb_tready_i) begin
            zdp_q <= 1'b0;
          end
          if (usb_sent_i) begin
            state_q <= BLK_DATI_ACK;
          end
        end
        BLK_DATI_ACK: begin
          // Any host handshake ends it, only ACK moves the toggle
          if (hsk_recv_i) begin
            state_q <= BLK_DONE;
          end
        end
        BLK_DATO_RX, BLK_DATO_NAK_RX: begin
          // Empty packets end on EOP alone
          if (rx_last_w || eop_rx_i) begin
            state_q <= BLK_DATO_HSK;
          end
        end
        BLK_DATO_HSK: begin
          if (hsk_sent_i) begin
            state_q <= BLK_DONE;
          end
        end
        BLK_DONE: begin
          // Dispatcher leaves BULK on the edge that samples done
          state_q <= BLK_IDLE;
          nak_q <= 1'b0;
        end
        default: begin
          state_q <= BLK_IDLE;
        end
      endcase
    end
  end

  // Per-endpoint DATA0/DATA1 tracking
  always_ff @(posedge clock) begin
    if (reset) begin
      toggle_q <= '0;
    end else if (state_q == BLK_DATO_HSK && hsk_sent_i && !nak_q) begin
      toggle_q[xact.endp] <= !toggle_q[xact.endp];
    end else if (state_q == BLK_DATI_ACK && hsk_ack_rx_w) begin
      toggle_q[xact.endp] <= !toggle_q[xact.endp];
    end
  end

  assign xact.done = (state_q == BLK_DONE);

  // Transmit select, user data in DATI_TX, empty beat otherwise
  assign usb_tvalid_o = sel_tx_w ? blk_tvalid_i : zdp_q;
  assign usb_tlast_o = sel_tx_w ? blk_tlast_i : zdp_q;
  assign usb_tkeep_o = sel_tx_w && blk_tkeep_i;
  assign usb_tdata_o = sel_tx_w ? blk_tdata_i : 8'h00;
  assign blk_tready_o = sel_tx_w && usb_tready_i;
  assign usb_tuser_o = {odd_w ? DATA1 : DATA0, 2'b11};

  // Receive path, sink only sees data it agreed to take
  assign usb_tready_o = (state_q == BLK_DATO_RX) ? blk_tready_i : 1'b1;
  assign blk_tvalid_o = (state_q == BLK_DATO_RX) && usb_tvalid_i;
  assign blk_tlast_o = usb_tlast_i;
  assign blk_tkeep_o = usb_tkeep_i;
  assign blk_tdata_o = usb_tdata_i;

  // OUT transactions always want a handshake
  assign hsk_req_o = (state_q == BLK_DATO_RX) || (state_q == BLK_DATO_NAK_RX) ||
                     (state_q == BLK_DATO_HSK);
  assign hsk_type_o = nak_q ? HSK_NAK : HSK_ACK;

endmodule

/* usb_transactor.sv */
`timescale 1ns/1ps
module usb_transactor
  import usb_xact_pkg::*;
#(
  parameter int BULK_EP_A = 1,
  parameter int BULK_EP_B = 2,
  parameter int EOP_DELAY = 5
) (
  input  logic               clock,
  input  logic               reset,
  input  logic [ADDR_W-1:0]  usb_addr_i,
  output err_code_t          err_code_o,
  // Bulk transfer control
  input  logic               blk_in_ready_i,
  input  logic               blk_out_ready_i,
  output logic               blk_start_o,
  output logic               blk_cycle_o,
  output logic [ENDP_W-1:0]  blk_endpt_o,
  // Bulk OUT stream to the user
  output logic               blk_tvalid_o,
  input  logic               blk_tready_i,
  output logic               blk_tlast_o,
  output logic               blk_tkeep_o,
  output logic [7:0]         blk_tdata_o,
  // Bulk IN stream from the user
  input  logic               blk_tvalid_i,
  output logic               blk_tready_o,
  input  logic               blk_tlast_i,
  input  logic               blk_tkeep_i,
  input  logic [7:0]         blk_tdata_i,
  // Decoded tokens
  input  logic               tok_recv_i,
  input  logic [ADDR_W-1:0]  tok_addr_i,
  input  logic [ENDP_W-1:0]  tok_endp_i,
  // Handshakes
  input  logic               hsk_recv_i,
  output logic               hsk_send_o,
  input  logic               hsk_sent_i,
  output hsk_type_t          hsk_type_o,
  // Packet events
  input  logic               usb_recv_i,
  input  logic               usb_sent_i,
  // Data from the decoder
  input  logic               usb_tvalid_i,
  output logic               usb_tready_o,
  input  logic               usb_tkeep_i,
  input  logic               usb_tlast_i,
  input  logic [TUSER_W-1:0] usb_tuser_i,
  input  logic [7:0]         usb_tdata_i,
  // Data to the encoder
  output logic               usb_tvalid_o,
  input  logic               usb_tready_i,
  output logic               usb_tkeep_o,
  output logic               usb_tlast_o,
  output logic [TUSER_W-1:0] usb_tuser_o,
  output logic [7:0]         usb_tdata_o
);

  logic hsk_req;
  hsk_type_t hsk_type;
  logic eop_rx;

  xact_if xact_bus ();

  assign blk_start_o = xact_bus.start;
  assign blk_endpt_o = xact_bus.endp;

  token_dispatch #(
    .BULK_EP_A(BULK_EP_A),
    .BULK_EP_B(BULK_EP_B)
  ) i_token_dispatch (
    .clock      (clock),
    .reset      (reset),
    .usb_addr_i (usb_addr_i),
    .tok_recv_i (tok_recv_i),
    .tok_addr_i (tok_addr_i),
    .tok_endp_i (tok_endp_i),
    .tok_type_i (tok_type_t'(usb_tuser_i[3:2])),
    .xact       (xact_bus.dispatch),
    .err_code_o (err_code_o),
    .blk_cycle_o(blk_cycle_o)
  );

  handshake_issuer #(
    .EOP_DELAY(EOP_DELAY)
  ) i_handshake_issuer (
    .clock     (clock),
    .reset     (reset),
    .usb_recv_i(usb_recv_i),
    .hsk_req_i (hsk_req),
    .hsk_type_i(hsk_type),
    .hsk_sent_i(hsk_sent_i),
    .eop_rx_o  (eop_rx),
    .hsk_send_o(hsk_send_o),
    .hsk_type_o(hsk_type_o)
  );

  bulk_engine i_bulk_engine (
    .clock          (clock),
    .reset          (reset),
    .xact           (xact_bus.engine),
    .blk_in_ready_i (blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .usb_sent_i     (usb_sent_i),
    .eop_rx_i       (eop_rx),
    .hsk_recv_i     (hsk_recv_i),
    .hsk_sent_i     (hsk_sent_i),
    .usb_tuser_i    (usb_tuser_i),
    .blk_tvalid_i   (blk_tvalid_i),
    .blk_tready_o   (blk_tready_o),
    .blk_tlast_i    (blk_tlast_i),
    .blk_tkeep_i    (blk_tkeep_i),
    .blk_tdata_i    (blk_tdata_i),
    .usb_tvalid_i   (usb_tvalid_i),
    .usb_tready_o   (usb_tready_o),
    .usb_tlast_i    (usb_tlast_i),
    .usb_tkeep_i    (usb_tkeep_i),
    .usb_tdata_i    (usb_tdata_i),
    .blk_tvalid_o   (blk_tvalid_o),
    .blk_tready_i   (blk_tready_i),
    .blk_tlast_o    (blk_tlast_o),
    .blk_tkeep_o    (blk_tkeep_o),
    .blk_tdata_o    (blk_tdata_o),
    .usb_tvalid_o   (usb_tvalid_o),
    .usb_tready_i   (usb_tready_i),
    .usb_tlast_o    (usb_tlast_o),
    .usb_tkeep_o    (usb_tkeep_o),
    .usb_tdata_o    (usb_tdata_o),
    .usb_tuser_o    (usb_tuser_o),
    .hsk_req_o      (hsk_req),
    .hsk_type_o     (hsk_type)
  );

endmodule

/* usb_transactor_chk.sv */
`timescale 1ns/1ps
module usb_transactor_chk
  import usb_xact_pkg::*;
#(
  parameter int BULK_EP_A = 1,
  parameter int BULK_EP_B = 2,
  parameter int EOP_DELAY = 5
) (
  input logic               clock,
  input logic               reset,
  input logic [ADDR_W-1:0]  usb_addr_i,
  input logic               tok_recv_i,
  input logic [ADDR_W-1:0]  tok_addr_i,
  input logic [ENDP_W-1:0]  tok_endp_i,
  input err_code_t          err_code_o,
  input logic               blk_in_ready_i,
  input logic               blk_out_ready_i,
  input logic               blk_start_o,
  input logic               blk_cycle_o,
  input logic [ENDP_W-1:0]  blk_endpt_o,
  input logic               blk_tvalid_o,
  input logic               blk_tready_i,
  input logic               blk_tlast_o,
  input logic               blk_tkeep_o,
  input logic [7:0]         blk_tdata_o,
  input logic               blk_tvalid_i,
  input logic               blk_tready_o,
  input logic               blk_tlast_i,
  input logic [7:0]         blk_tdata_i,
  input logic               hsk_recv_i,
  input logic               hsk_send_o,
  input logic               hsk_sent_i,
  input hsk_type_t          hsk_type_o,
  input logic               usb_recv_i,
  input logic               usb_tvalid_i,
  input logic               usb_tready_o,
  input logic               usb_tlast_i,
  input logic               usb_tkeep_i,
  input logic               usb_tready_i,
  input logic [TUSER_W-1:0] usb_tuser_i,
  input logic [7:0]         usb_tdata_i,
  input logic               usb_tvalid_o,
  input logic               usb_tlast_o,
  input logic               usb_tkeep_o,
  input logic [TUSER_W-1:0] usb_tuser_o,
  input logic [7:0]         usb_tdata_o
);

  int unsigned fail_count = 0;

  logic dir_in_q;
  logic [ENDP_W-1:0] ep_q;
  logic in_rdy_q;
  logic out_rdy_q;
  logic [7:0] since_q;
  logic [NUM_TOGGLE-1:0] exp_tog_q;

  logic tok_mine_w;
  logic ep_ok_w;
  logic idle_w;
  logic zdp_mode_w;
  logic tx_mode_w;

  assign tok_mine_w = tok_recv_i && (tok_addr_i == usb_addr_i);
  assign ep_ok_w = (tok_endp_i == ENDP_W'(BULK_EP_A)) || (tok_endp_i == ENDP_W'(BULK_EP_B));
  assign idle_w = !blk_cycle_o && (err_code_o == ER_NONE);
  assign zdp_mode_w = blk_cycle_o && dir_in_q && !in_rdy_q;
  assign tx_mode_w = blk_cycle_o && dir_in_q && in_rdy_q;

  // Direction, endpoint and user readiness as seen when the transaction opened
  always_ff @(posedge clock) begin
    if (tok_mine_w && !blk_cycle_o) begin
      dir_in_q <= (usb_tuser_i[3:2] == TOK_IN);
      ep_q <= tok_endp_i;
    end
    if (blk_start_o) begin
      in_rdy_q <= blk_in_ready_i;
      out_rdy_q <= blk_out_ready_i;
    end
  end

  // Cycles since the last received packet
  always_ff @(posedge clock) begin
    if (reset) begin
      since_q <= 8'hff;
    end else if (usb_recv_i) begin
      since_q <= 8'd1;
    end else if (since_q != 8'hff) begin
      since_q <= since_q + 8'd1;
    end
  end

  // Expected DATA0/DATA1 per endpoint, moved only by acknowledged transfers
  always_ff @(posedge clock) begin
    if (reset) begin
      exp_tog_q <= '0;
    end else if (blk_cycle_o && dir_in_q && hsk_recv_i && usb_tuser_i[3:2] == HSK_ACK) begin
      exp_tog_q[ep_q] <= !exp_tog_q[ep_q];
    end else if (blk_cycle_o && !dir_in_q && hsk_send_o && hsk_sent_i &&
                 hsk_type_o == HSK_ACK) begin
      exp_tog_q[ep_q] <= !exp_tog_q[ep_q];
    end
  end

  a_reset_state: assert property (@(posedge clock)
    reset |=> !blk_start_o && !blk_cycle_o && !hsk_send_o && !usb_tvalid_o &&
              err_code_o == ER_NONE)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: outputs not idle after reset", $time);
    end

  a_foreign_addr: assert property (@(posedge clock) disable iff (reset)
    tok_recv_i && tok_addr_i != usb_addr_i && !blk_cycle_o |=> !blk_start_o)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: transaction started for another address", $time);
    end

  a_bulk_start: assert property (@(posedge clock) disable iff (reset)
    idle_w && tok_mine_w && (usb_tuser_i[3:2] == TOK_IN || usb_tuser_i[3:2] == TOK_OUT)
    |=> blk_start_o && blk_cycle_o && err_code_o == ($past(ep_ok_w) ? ER_NONE : ER_ENDP))
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: bulk token start or error code wrong", $time);
    end

  a_endpt: assert property (@(posedge clock) disable iff (reset)
    blk_cycle_o |-> blk_endpt_o == ep_q)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: blk_endpt_o differs from token endpoint", $time);
    end

  a_setup_tokn: assert property (@(posedge clock) disable iff (reset)
    idle_w && tok_mine_w && usb_tuser_i[3:2] == TOK_SETUP
    |=> !blk_start_o && err_code_o == ER_TOKN)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: SETUP token not flagged TOKN", $time);
    end

  a_hsk_delay: assert property (@(posedge clock) disable iff (reset)
    $rose(hsk_send_o) |-> since_q == 8'(EOP_DELAY + 2))
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: handshake after %0d cycles", $time, since_q);
    end

  a_hsk_type: assert property (@(posedge clock) disable iff (reset)
    $rose(hsk_send_o) |-> hsk_type_o == (out_rdy_q ? HSK_ACK : HSK_NAK))
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: handshake type does not follow sink readiness", $time);
    end

  a_hsk_hold: assert property (@(posedge clock) disable iff (reset)
    hsk_send_o |=> (hsk_send_o != $past(hsk_sent_i)))
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: hsk_send_o not held until hsk_sent_i", $time);
    end

  a_out_fwd: assert property (@(posedge clock) disable iff (reset)
    blk_tvalid_o |-> blk_cycle_o && !dir_in_q && out_rdy_q && blk_tdata_o == usb_tdata_i &&
                     blk_tlast_o == usb_tlast_i && blk_tkeep_o == usb_tkeep_i)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: OUT beat forwarded wrongly", $time);
    end

  // Ready sink sees every host beat, a NAKed packet is drained
  a_out_flow: assert property (@(posedge clock) disable iff (reset)
    blk_cycle_o && !dir_in_q && usb_tvalid_i
    |-> blk_tvalid_o == out_rdy_q && usb_tready_o == (out_rdy_q ? blk_tready_i : 1'b1))
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: OUT beat not passed or drained", $time);
    end

  a_in_data: assert property (@(posedge clock) disable iff (reset)
    tx_mode_w && blk_tvalid_i
    |-> usb_tvalid_o && usb_tdata_o == blk_tdata_i && usb_tlast_o == blk_tlast_i &&
        blk_tready_o == usb_tready_i)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: IN data differs from source", $time);
    end

  a_zdp_beat: assert property (@(posedge clock) disable iff (reset)
    blk_start_o && dir_in_q && !blk_in_ready_i |=> usb_tvalid_o)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: no ZDP beat for an unready source", $time);
    end

  a_zdp_shape: assert property (@(posedge clock) disable iff (reset)
    zdp_mode_w && usb_tvalid_o |-> usb_tlast_o && !usb_tkeep_o && !blk_tready_o)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: ZDP beat not tlast with empty tkeep", $time);
    end

  a_zdp_hold: assert property (@(posedge clock) disable iff (reset)
    zdp_mode_w && usb_tvalid_o && !usb_tready_i |=> usb_tvalid_o)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: ZDP beat dropped under back-pressure", $time);
    end

  a_zdp_once: assert property (@(posedge clock) disable iff (reset)
    zdp_mode_w && usb_tvalid_o && usb_tready_i |=> !usb_tvalid_o)
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: more than one ZDP beat", $time);
    end

  a_in_pid: assert property (@(posedge clock) disable iff (reset)
    blk_cycle_o && dir_in_q && usb_tvalid_o
    |-> usb_tuser_o == {(exp_tog_q[ep_q] ? DATA1 : DATA0), 2'b11})
    else begin
      fail_count = fail_count + 1;
      $error("MISMATCH %0t: wrong data PID on endpoint %0d", $time, ep_q);
    end

endmodule

/* tb_usb_transactor.sv */
`timescale 1ns/1ps
module tb_usb_transactor;
  import usb_xact_pkg::*;

  localparam int EOP_DELAY = 5;
  localparam logic [ADDR_W-1:0] DEV_ADDR = 7'h2a;
  // Ten sequences of at most 400 cycles each
  localparam int SEQ_CYCLES = 400;
  localparam int NUM_SEQ = 10;
  localparam int TIMEOUT_CYCLES = SEQ_CYCLES * NUM_SEQ;

  logic clock;
  logic reset;
  logic [ADDR_W-1:0] usb_addr_i;
  err_code_t err_code_o;
  logic blk_in_ready_i;
  logic blk_out_ready_i;
  logic blk_start_o;
  logic blk_cycle_o;
  logic [ENDP_W-1:0] blk_endpt_o;
  logic blk_tvalid_o;
  logic blk_tready_i;
  logic blk_tlast_o;
  logic blk_tkeep_o;
  logic [7:0] blk_tdata_o;
  logic blk_tvalid_i;
  logic blk_tready_o;
  logic blk_tlast_i;
  logic blk_tkeep_i;
  logic [7:0] blk_tdata_i;
  logic tok_recv_i;
  logic [ADDR_W-1:0] tok_addr_i;
  logic [ENDP_W-1:0] tok_endp_i;
  logic hsk_recv_i;
  logic hsk_send_o;
  logic hsk_sent_i;
  hsk_type_t hsk_type_o;
  logic usb_recv_i;
  logic usb_sent_i;
  logic usb_tvalid_i;
  logic usb_tready_o;
  logic usb_tkeep_i;
  logic usb_tlast_i;
  logic [TUSER_W-1:0] usb_tuser_i;
  logic [7:0] usb_tdata_i;
  logic usb_tvalid_o;
  logic usb_tready_i;
  logic usb_tkeep_o;
  logic usb_tlast_o;
  logic [TUSER_W-1:0] usb_tuser_o;
  logic [7:0] usb_tdata_o;

  int unsigned cycle_count = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned base_fail = 0;

  usb_transactor #(
    .BULK_EP_A(1),
    .BULK_EP_B(2),
    .EOP_DELAY(EOP_DELAY)
  ) i_usb_transactor (.*);

  bind usb_transactor usb_transactor_chk #(
    .BULK_EP_A(BULK_EP_A),
    .BULK_EP_B(BULK_EP_B),
    .EOP_DELAY(EOP_DELAY)
  ) i_chk (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  // Hang guard
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic apply_reset();
    reset = 1'b1;
    repeat (8) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
  endtask

  task automatic begin_test();
    base_fail = i_usb_transactor.i_chk.fail_count;
  endtask

  task automatic report_test(input string name);
    int unsigned n;
    n = i_usb_transactor.i_chk.fail_count - base_fail;
    tests_run = tests_run + 1;
    if (n != 0) begin
      tests_failed = tests_failed + 1;
    end
    $display("test %0d %s: %s (%0d assertion failures)", tests_run, name,
             (n == 0) ? "ok" : "FAILED", n);
  endtask

  // Token lasts one cycle, type rides in tuser[3:2]
  task automatic send_token(input logic [ADDR_W-1:0] addr, input logic [ENDP_W-1:0] endp,
                            input tok_type_t kind);
    tok_recv_i = 1'b1;
    tok_addr_i = addr;
    tok_endp_i = endp;
    usb_tuser_i = {kind, 2'b01};
    @(negedge clock);
    tok_recv_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (blk_cycle_o) @(negedge clock);
    @(negedge clock);
  endtask

  task automatic out_xact(input logic [ENDP_W-1:0] endp, input logic ready);
    int len;
    len = $urandom_range(1, 16);
    blk_out_ready_i = ready;
    blk_tready_i = 1'b1;
    send_token(DEV_ADDR, endp, TOK_OUT);
    while (!blk_start_o) @(negedge clock);
    @(negedge clock);
    for (int i = 0; i < len; i++) begin
      usb_tvalid_i = 1'b1;
      usb_tdata_i = 8'($urandom);
      usb_tkeep_i = 1'b1;
      usb_tlast_i = (i == len - 1);
      @(negedge clock);
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
    // End of the data packet starts the turnaround wait
    usb_recv_i = 1'b1;
    @(negedge clock);
    usb_recv_i = 1'b0;
    while (!hsk_send_o) @(negedge clock);
    repeat ($urandom_range(0, 2)) @(negedge clock);
    hsk_sent_i = 1'b1;
    @(negedge clock);
    hsk_sent_i = 1'b0;
    wait_idle();
  endtask

  task automatic in_xact(input logic [ENDP_W-1:0] endp, input logic ready,
                         input logic ack);
    int len;
    int i;
    len = $urandom_range(1, 16);
    blk_in_ready_i = ready;
    send_token(DEV_ADDR, endp, TOK_IN);
    while (!blk_start_o) @(negedge clock);
    @(negedge clock);
    if (ready) begin
      i = 0;
      while (i < len) begin
        blk_tvalid_i = 1'b1;
        blk_tdata_i = 8'($urandom);
        blk_tkeep_i = 1'b1;
        blk_tlast_i = (i == len - 1);
        usb_tready_i = 1'($urandom_range(0, 1));
        @(posedge clock);
        if (usb_tready_i) begin
          i = i + 1;
        end
        @(negedge clock);
      end
      blk_tvalid_i = 1'b0;
      blk_tlast_i = 1'b0;
    end else begin
      // Encoder stalls the empty beat, then takes it
      usb_tready_i = 1'b0;
      repeat (3) @(negedge clock);
      usb_tready_i = 1'b1;
      @(negedge clock);
      usb_tready_i = 1'b0;
      repeat (2) @(negedge clock);
    end
    usb_tready_i = 1'b0;
    usb_sent_i = 1'b1;
    @(negedge clock);
    usb_sent_i = 1'b0;
    repeat (3) @(negedge clock);
    hsk_recv_i = 1'b1;
    usb_tuser_i = {ack ? HSK_ACK : HSK_NAK, 2'b10};
    @(negedge clock);
    hsk_recv_i = 1'b0;
    wait_idle();
  endtask

  initial begin
    void'($urandom(32'h6d6a));
    reset = 1'b1;
    usb_addr_i = DEV_ADDR;
    blk_in_ready_i = 1'b0;
    blk_out_ready_i = 1'b0;
    blk_tready_i = 1'b0;
    blk_tvalid_i = 1'b0;
    blk_tlast_i = 1'b0;
    blk_tkeep_i = 1'b0;
    blk_tdata_i = 8'h00;
    tok_recv_i = 1'b0;
    tok_addr_i = '0;
    tok_endp_i = '0;
    hsk_recv_i = 1'b0;
    hsk_sent_i = 1'b0;
    usb_recv_i = 1'b0;
    usb_sent_i = 1'b0;
    usb_tvalid_i = 1'b0;
    usb_tkeep_i = 1'b0;
    usb_tlast_i = 1'b0;
    usb_tuser_i = '0;
    usb_tdata_i = 8'h00;
    usb_tready_i = 1'b0;

    begin_test();
    apply_reset();
    repeat (2) @(negedge clock);
    report_test("reset state");

    begin_test();
    send_token(DEV_ADDR + 7'd1, 4'd1, TOK_IN);
    repeat (4) @(negedge clock);
    in_xact(4'd3, 1'b1, 1'b1);
    send_token(DEV_ADDR, 4'd0, TOK_SETUP);
    repeat (4) @(negedge clock);
    // DUMP only leaves through reset
    apply_reset();
    report_test("address and endpoint dispatch");

    begin_test();
    out_xact(4'd1, 1'b1);
    out_xact(4'd2, 1'b0);
    report_test("handshake timing and OUT forwarding");

    begin_test();
    in_xact(4'd1, 1'b1, 1'b1);
    in_xact(4'd2, 1'b0, 1'b1);
    report_test("IN data and ZDP");

    begin_test();
    in_xact(4'd1, 1'b1, 1'b1);
    in_xact(4'd1, 1'b1, 1'b1);
    in_xact(4'd1, 1'b1, 1'b0);
    out_xact(4'd2, 1'b1);
    out_xact(4'd2, 1'b0);
    in_xact(4'd2, 1'b1, 1'b1);
    report_test("data toggle");

    $display("tests run %0d, tests failed %0d, assertion failures %0d",
             tests_run, tests_failed, i_usb_transactor.i_chk.fail_count);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
usb_xact_pkg.sv
xact_if.sv
token_dispatch.sv
handshake_issuer.sv
bulk_engine.sv
usb_transactor.sv
usb_transactor_chk.sv
tb_usb_transactor.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_usb_transactor
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
RUN_ARGS ?= +verilator+error+limit+1000
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
